/* stream_width_top.f */
+incdir+src
src/stream_width_pkg.sv
src/byte_packer.sv
src/word_fifo.sv
src/lane_unpacker.sv
src/stream_width_top.sv
verif/tb_clock_gen.sv
verif/tb_stream_width.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_stream_width \
    -f stream_width_top.f -o tb_stream_width > build.log 2>&1 ||
    { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_stream_width > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* verif/tb_stream_width.sv */
/* Packet table test of the stream width adapter with three out_ready phases.
   Data is compared on kept lanes only, the high lane of an odd tail is free */
module tb_stream_width
    import stream_width_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////////////////////
    // Tables

    localparam int num_packets = 13;
    localparam int num_phases  = 3;
    localparam int wait_limit  = 1000;

    // Packets, bytes count up from the first value
    int    pkt_len   [num_packets] = '{4, 8, 1, 2, 3, 5, 7, 8, 1, 8, 6, 5, 8};
    byte_t pkt_first [num_packets] = '{8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h60, 8'h70,
                                       8'h80, 8'h90, 8'ha0, 8'hb0, 8'hc0, 8'hd0};
    user_t pkt_user  [num_packets] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7,
                                       4'h8, 4'h9, 4'ha, 4'hb, 4'hc, 4'hd};

    // out_ready phases in output beats, last one runs to the end
    int phase_beats [num_phases] = '{6, 8, 1000};
    int phase_pct   [num_phases] = '{100, 50, 10};

    ////////////////////////////////////////////////////////////////////////////
    // DUT and clock

    logic         axis_in;
    logic         arst_n;
    narrow_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    out_beat_t    out_beat;
    logic         out_valid;
    logic         out_ready;

    out_beat_t    expected [$];
    int           beats_seen = 0;
    int           cur_phase  = 0;
    bit           rx_done    = 1'b0;
    bit           stall_seen = 1'b0;

    tb_clock_gen u_tb_clock_gen (
        .axis_in (axis_in),
        .arst_n  (arst_n)
    );

    stream_width_top u_stream_width_top (
        .axis_in   (axis_in),
        .arst_n    (arst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and compares

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped on error");
    endtask

    task automatic check_half(string name, half_t got, half_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED time %0t %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_keep(string name, half_keep_t got, half_keep_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED time %0t %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_user(string name, user_t got, user_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED time %0t %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED time %0t %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    // Handshake flags
    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED time %0t %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected model

    // Pairs from lane 0 up, odd tail keeps only the low lane
    task automatic build_expected();
        out_beat_t beat;
        int        pos;
        for (int p = 0; p < num_packets; p++) begin
            pos = 0;
            while (pos < pkt_len[p]) begin
                beat           = '0;
                beat.user      = pkt_user[p];
                beat.data[7:0] = pkt_first[p] + 8'(pos);
                beat.keep      = 2'b01;
                if (pos + 1 < pkt_len[p]) begin
                    beat.data[15:8] = pkt_first[p] + 8'(pos + 1);
                    beat.keep       = 2'b11;
                end
                beat.last = (pos + 2 >= pkt_len[p]);
                expected.push_back(beat);
                pos += 2;
            end
        end
    endtask

    function automatic int phase_of(int beats);
        int acc = 0;
        for (int k = 0; k < num_phases; k++) begin
            acc += phase_beats[k];
            if (beats < acc) begin
                return k;
            end
        end
        return num_phases - 1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and response

    task automatic wait_reset_release();
        int cycles = 0;
        while (arst_n !== 1'b1) begin
            @(negedge axis_in);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("Reset was never released");
            end
        end
    endtask

    // No output and ready input before any byte
    task automatic check_idle_after_reset();
        @(posedge axis_in);
        repeat (20) begin
            @(negedge axis_in);
            check_flag("in_ready", in_ready, 1'b1);
            check_flag("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic send_packets();
        int cycles;
        for (int p = 0; p < num_packets; p++) begin
            for (int b = 0; b < pkt_len[p]; b++) begin
                @(posedge axis_in);
                #1;
                in_valid     = 1'b1;
                in_beat.data = pkt_first[p] + 8'(b);
                in_beat.user = pkt_user[p];
                in_beat.last = (b == pkt_len[p] - 1);
                cycles = 0;
                // Sampled mid cycle, transfer on the next edge
                @(negedge axis_in);
                while (!in_ready) begin
                    if (phase_pct[cur_phase] == 10) begin
                        stall_seen = 1'b1;
                    end
                    cycles++;
                    if (cycles > wait_limit) begin
                        abort_run($sformatf("in_ready stayed low on byte %0d of packet %0d",
                                            b, p));
                    end
                    @(negedge axis_in);
                end
            end
        end
        @(posedge axis_in);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drive_out_ready();
        while (!rx_done) begin
            @(posedge axis_in);
            #1;
            cur_phase = phase_of(beats_seen);
            out_ready = (($urandom % 100) < phase_pct[cur_phase]);
        end
        out_ready = 1'b1;
    endtask

    task automatic collect_beats();
        out_beat_t got;
        out_beat_t exp;
        half_t     mask;
        int        cycles;
        foreach (expected[i]) begin
            exp    = expected[i];
            cycles = 0;
            @(negedge axis_in);
            while (!(out_valid && out_ready)) begin
                cycles++;
                if (cycles > wait_limit) begin
                    abort_run($sformatf("Output beat %0d never came", i));
                end
                @(negedge axis_in);
            end
            got  = out_beat;
            mask = {{8{got.keep[1]}}, {8{got.keep[0]}}};
            check_keep($sformatf("out_beat.keep[%0d]", i), got.keep, exp.keep);
            check_half($sformatf("out_beat.data[%0d]", i), got.data & mask, exp.data);
            check_user($sformatf("out_beat.user[%0d]", i), got.user, exp.user);
            check_last($sformatf("out_beat.last[%0d]", i), got.last, exp.last);
            beats_seen++;
        end
        rx_done = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        void'($urandom(32'h829c));
        build_expected();
        wait_reset_release();
        check_idle_after_reset();
        fork
            send_packets();
            collect_beats();
            drive_out_ready();
        join
        // Stream drained, nothing extra may follow
        repeat (10) begin
            @(negedge axis_in);
            check_flag("out_valid", out_valid, 1'b0);
        end
        if (!stall_seen) begin
            abort_run("in_ready never fell while out_ready was at 10 percent");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* verif/tb_clock_gen.sv */
/* Testbench clock of 10 ns and an active low reset held for 16 rising edges.
   Reset is released 1 ns after an edge, in step with the stimulus */
module tb_clock_gen (
    output logic axis_in,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 5;
    localparam int reset_cycles = 16;

    // Free running clock
    initial begin
        axis_in = 1'b0;
        forever #half_period axis_in = ~axis_in;
    end

    // Reset from time zero
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge axis_in);
        #1;
        arst_n = 1'b1;
    end

endmodule

/* src/stream_width_top.sv */
/* Byte stream to 2-byte stream adapter through a 4-byte word FIFO.
   Widths are fixed by the params header, latency depends on back-pressure */
module stream_width_top
    import stream_width_pkg::*;
(
    input  logic         axis_in,
    input  logic         arst_n,
    // Narrow input stream
    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    // Output stream
    output out_beat_t    out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal links

    // Packer to FIFO
    wide_beat_t pack_beat;
    logic       pack_valid;
    logic       pack_ready;

    // FIFO to unpacker
    wide_beat_t fifo_beat;
    logic       fifo_valid;
    logic       fifo_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Data path

    // Bytes into words
    byte_packer u_byte_packer (
        .axis_in    (axis_in),
        .arst_n     (arst_n),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .pack_beat  (pack_beat),
        .pack_valid (pack_valid),
        .pack_ready (pack_ready)
    );

    // Burst buffer
    word_fifo u_word_fifo (
        .axis_in  (axis_in),
        .arst_n   (arst_n),
        .wr_beat  (pack_beat),
        .wr_valid (pack_valid),
        .wr_ready (pack_ready),
        .rd_beat  (fifo_beat),
        .rd_valid (fifo_valid),
        .rd_ready (fifo_ready)
    );

    // Words into 2-byte beats
    lane_unpacker u_lane_unpacker (
        .axis_in    (axis_in),
        .arst_n     (arst_n),
        .word_beat  (fifo_beat),
        .word_valid (fifo_valid),
        .word_ready (fifo_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

/* src/lane_unpacker.sv */
/* Wide to narrow unpacker with a registered output, at least two beats per word.
   Assumes keep is contiguous from lane 0, sparse keep is not handled */
`include "stream_width_params.svh"

module lane_unpacker
    import stream_width_pkg::*;
(
    input  logic       axis_in,
    input  logic       arst_n,
    input  wide_beat_t word_beat,
    input  logic       word_valid,
    output logic       word_ready,
    output out_beat_t  out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    ////////////////////////////////////////////////////////////////////////////
    // Constants

    // Output beats per wide word
    localparam int pairs     = `SW_WIDE_BYTES / `SW_OUT_BYTES;
    localparam int pair_bits = $clog2(pairs);
    localparam int out_bits  = `SW_OUT_BYTES * 8;

    ////////////////////////////////////////////////////////////////////////////
    // Signals

    unpack_state_t          state;

    // Lanes not yet shown, shifted down by one beat per step
    word_t                  rest_data;
    word_keep_t             rest_keep;
    logic                   word_last;
    // Beat index within the current word
    logic [pair_bits-1:0]   pair_idx;

    logic                   more;
    logic                   take;
    logic                   step;
    logic                   final_step;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake

    // Another nonempty pair still waits behind the current beat
    assign more = (pair_idx != pair_bits'(pairs - 1)) &&
                  (rest_keep[`SW_OUT_BYTES-1:0] != '0);

    // Ready on the last pair so words go back to back
    assign word_ready = (state == UNPACK_IDLE) || (out_ready && !more);
    assign take       = word_valid && word_ready;
    assign step       = (state == UNPACK_SEND) && out_ready && more;

    // Beat loaded by this step is the word's final one
    assign final_step = (pair_idx == pair_bits'(pairs - 2)) ||
                        (rest_keep[`SW_WIDE_BYTES-1:`SW_OUT_BYTES] == '0);

    assign out_valid = (state == UNPACK_SEND);

    ////////////////////////////////////////////////////////////////////////////
    // FSM and lane tracking

    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            state     <= UNPACK_IDLE;
            pair_idx  <= '0;
            rest_keep <= '0;
        end else begin
            if (take) begin
                // New word, low pair goes out first
                state     <= UNPACK_SEND;
                pair_idx  <= '0;
                rest_keep <= word_beat.keep >> `SW_OUT_BYTES;
            end else if (step) begin
                pair_idx  <= pair_idx + 1'b1;
                rest_keep <= rest_keep >> `SW_OUT_BYTES;
            end else if ((state == UNPACK_SEND) && out_ready) begin
                // Last beat gone, nothing waiting upstream
                state <= UNPACK_IDLE;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output and word registers

    always_ff @(posedge axis_in) begin
        if (take) begin
            out_beat.data <= word_beat.data[out_bits-1:0];
            out_beat.keep <= word_beat.keep[`SW_OUT_BYTES-1:0];
            out_beat.user <= word_beat.user;
            // Single-beat word carries last right away
            out_beat.last <= word_beat.last &&
                             (word_beat.keep[`SW_WIDE_BYTES-1:`SW_OUT_BYTES] == '0);
            rest_data     <= word_beat.data >> out_bits;
            word_last     <= word_beat.last;
        end else if (step) begin
            // User stays, same value on every beat of a word
            out_beat.data <= rest_data[out_bits-1:0];
            out_beat.keep <= rest_keep[`SW_OUT_BYTES-1:0];
            out_beat.last <= word_last && final_step;
            rest_data     <= rest_data >> out_bits;
        end
    end

endmodule

/* src/word_fifo.sv */
/* Show-ahead FIFO of wide beats, depth a power of two and at least 2.
   No pass-through, a write shows at the read side one cycle later */
`include "stream_width_params.svh"

module word_fifo
    import stream_width_pkg::*;
#(
    parameter int depth = `SW_FIFO_DEPTH
) (
    input  logic       axis_in,
    input  logic       arst_n,
    input  wide_beat_t wr_beat,
    input  logic       wr_valid,
    output logic       wr_ready,
    output wide_beat_t rd_beat,
    output logic       rd_valid,
    input  logic       rd_ready
);

    ////////////////////////////////////////////////////////////////////////////
    // Constants

    localparam int addr_bits = $clog2(depth);

    ////////////////////////////////////////////////////////////////////////////
    // Signals

    // Storage
    wide_beat_t           mem [depth];

    // Extra MSB tells full from empty
    logic [addr_bits:0]   wr_ptr;
    logic [addr_bits:0]   rd_ptr;

    logic                 full;
    logic                 empty;
    logic                 push;
    logic                 pop;

    ////////////////////////////////////////////////////////////////////////////
    // Status

    assign empty = (wr_ptr == rd_ptr);

    // Same address, opposite wrap bit
    assign full  = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                   (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);

    assign wr_ready = !full;
    assign rd_valid = !empty;

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    // Head of queue always on the read port
    assign rd_beat = mem[rd_ptr[addr_bits-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Pointers

    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Write port
    always_ff @(posedge axis_in) begin
        if (push) begin
            mem[wr_ptr[addr_bits-1:0]] <= wr_beat;
        end
    end

endmodule

/* src/byte_packer.sv */
/* Narrow to wide packer, one finished word plus one accumulating word.
   Input keep is not carried, so every accepted input byte counts as valid */
`include "stream_width_params.svh"

module byte_packer
    import stream_width_pkg::*;
(
    input  logic         axis_in,
    input  logic         arst_n,
    input  narrow_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output wide_beat_t   pack_beat,
    output logic         pack_valid,
    input  logic         pack_ready
);

    ////////////////////////////////////////////////////////////////////////////
    // Constants

    // Narrow beats per wide word
    localparam int lanes    = `SW_WIDE_BYTES / `SW_IN_BYTES;
    localparam int cnt_bits = $clog2(lanes + 1);
    localparam int in_bits  = `SW_IN_BYTES * 8;

    ////////////////////////////////////////////////////////////////////////////
    // Signals

    // Accumulator, data enters at the top and shifts down
    word_t                acc_data;
    word_keep_t           acc_keep;
    user_t                acc_user;
    logic                 acc_last;
    logic [cnt_bits-1:0]  acc_cnt;
    // Word complete, waiting for the output register
    logic                 acc_done;
    // Set on the first edge after reset release
    logic                 armed;

    logic                 take;
    logic                 move;
    word_t                align_data;

    logic [cnt_bits-1:0]  base_cnt;
    word_keep_t           base_keep;
    logic [cnt_bits-1:0]  nxt_cnt;
    word_keep_t           nxt_keep;
    logic                 nxt_done;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake

    // Output register free or draining this cycle
    assign move     = acc_done && (!pack_valid || pack_ready);

    // Stall only with a full accumulator and a pending finished word
    assign in_ready = armed && (!acc_done || !pack_valid || pack_ready);
    assign take     = in_valid && in_ready;

    // Partial word sits in the top lanes, bring it down to lane 0
    assign align_data = acc_data >> ((lanes - int'(acc_cnt)) * in_bits);

    ////////////////////////////////////////////////////////////////////////////
    // Next accumulator state

    always_comb begin
        // Moving word frees the accumulator for the incoming byte
        base_cnt  = move ? '0 : acc_cnt;
        base_keep = move ? '0 : acc_keep;
        nxt_cnt   = base_cnt;
        nxt_keep  = base_keep;
        nxt_done  = acc_done && !move;
        if (take) begin
            nxt_cnt = base_cnt + 1'b1;
            // One keep bit per byte, filling from lane 0 up
            nxt_keep[base_cnt*`SW_IN_BYTES +: `SW_IN_BYTES] = '1;
            nxt_done = (nxt_cnt == cnt_bits'(lanes)) || in_beat.last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control registers

    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            armed      <= 1'b0;
            acc_cnt    <= '0;
            acc_keep   <= '0;
            acc_done   <= 1'b0;
            pack_valid <= 1'b0;
        end else begin
            armed    <= 1'b1;
            acc_cnt  <= nxt_cnt;
            acc_keep <= nxt_keep;
            acc_done <= nxt_done;
            // Drain first, a new word may refill in the same cycle
            if (pack_valid && pack_ready) begin
                pack_valid <= 1'b0;
            end
            if (move) begin
                pack_valid <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload registers

    always_ff @(posedge axis_in) begin
        if (take) begin
            // Shift register, newest byte at the top
            acc_data <= {in_beat.data, acc_data[`SW_WIDE_BYTES*8-1:in_bits]};
            // User and last of the completing byte win
            acc_user <= in_beat.user;
            acc_last <= in_beat.last;
        end
        if (move) begin
            pack_beat <= '{data: align_data, keep: acc_keep, user: acc_user, last: acc_last};
        end
    end

endmodule

/* src/stream_width_pkg.sv */
/* Shared types of the stream width adapter. Widths come from the params
   header, so the package must be compiled with src/ on the include path */
`include "stream_width_params.svh"

package stream_width_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Plain vectors

    // One narrow input beat of data
    typedef logic [`SW_IN_BYTES*8-1:0]   byte_t;

    // Wide word and its byte enables
    typedef logic [`SW_WIDE_BYTES*8-1:0] word_t;
    typedef logic [`SW_WIDE_BYTES-1:0]   word_keep_t;

    // Output beat data and byte enables
    typedef logic [`SW_OUT_BYTES*8-1:0]  half_t;
    typedef logic [`SW_OUT_BYTES-1:0]    half_keep_t;

    // Sideband carried alongside every beat
    typedef logic [`SW_USER_BITS-1:0]    user_t;

    ////////////////////////////////////////////////////////////////////////////
    // Beat structs, one per link

    // Narrow input, every byte valid
    typedef struct packed {
        byte_t data;
        user_t user;
        logic  last;
    } narrow_beat_t;

    // Wide path, keep contiguous from lane 0
    typedef struct packed {
        word_t      data;
        word_keep_t keep;
        user_t      user;
        logic       last;
    } wide_beat_t;

    // Output, keep 2'b11 or 2'b01 on an odd tail
    typedef struct packed {
        half_t      data;
        half_keep_t keep;
        user_t      user;
        logic       last;
    } out_beat_t;

    // Unpacker FSM
    typedef enum logic {
        UNPACK_IDLE,
        UNPACK_SEND
    } unpack_state_t;

endpackage

/* src/stream_width_params.svh */
/* Build-time widths of the stream width adapter. SW_WIDE_BYTES must be a whole
   multiple of SW_IN_BYTES and of SW_OUT_BYTES, with at least two output beats per word */
`ifndef STREAM_WIDTH_PARAMS_SVH
`define STREAM_WIDTH_PARAMS_SVH

// Narrow input side, bytes per beat
`define SW_IN_BYTES 1

// Internal word between packer and unpacker
// Must divide evenly by both end widths
`define SW_WIDE_BYTES 4

// Output side, bytes per beat
`define SW_OUT_BYTES 2

// Word FIFO depth, power of two and at least 2
`define SW_FIFO_DEPTH 4

// Sideband user field, copied and never sliced
`define SW_USER_BITS 4

`endif
